//--- logic/noc_config.svh
/*
 * Build constants for the 2D mesh network on chip.
 * Include this header in any file that sizes flits, ports, nodes or buffers.
 * Change the mesh size here. NOC_DEST_WIDTH must cover NOC_NODES node numbers.
 */

`ifndef NOC_CONFIG_SVH
`define NOC_CONFIG_SVH

// Bits per flit
`define NOC_FLIT_WIDTH 32

// Mesh width and height in nodes
`define NOC_X 2
`define NOC_Y 2
`define NOC_NODES (`NOC_X * `NOC_Y)

// Destination field at the top of a head flit
`define NOC_DEST_WIDTH 2

// Entries in each router input buffer
`define NOC_BUFFER_DEPTH 4

// Local, north, east, south, west
`define NOC_PORTS 5

`endif

//--- logic/noc_pkg.sv
/*
 * Shared types for the mesh routers.
 * Refer to these by scoped name (noc_pkg::flit_t and so on).
 * The port direction enum is the index into every per-port array.
 */

`default_nettype none

`include "noc_config.svh"

package noc_pkg;

  // One flit, the destination sits in the top bits of a head flit
  typedef logic [`NOC_FLIT_WIDTH-1:0] flit_t;

  // Node number, x + y * NOC_X
  typedef logic [`NOC_DEST_WIDTH-1:0] node_id_t;

  // One bit per router port
  typedef logic [`NOC_PORTS-1:0] port_vec_t;

  // Router port directions
  typedef enum logic [2:0] {
    DIR_LOCAL = 3'd0,
    DIR_NORTH = 3'd1,
    DIR_EAST  = 3'd2,
    DIR_SOUTH = 3'd3,
    DIR_WEST  = 3'd4
  } dir_e;

  // Output port ownership
  typedef enum logic {
    PORT_IDLE = 1'b0,
    PORT_BUSY = 1'b1
  } port_state_e;

endpackage

`default_nettype wire

//--- logic/noc_input_fifo.sv
/*
 * Input flit buffer for one router port.
 * The write side is a valid/ready link, the read side shows the oldest flit
 * at the head and drops it when pop is high. Each entry keeps its last bit.
 */

`timescale 1ns/100ps
`default_nettype none

`include "noc_config.svh"

module noc_input_fifo (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           push_valid,
  input  noc_pkg::flit_t push_flit,
  input  logic           push_last,
  output logic           push_ready,
  output noc_pkg::flit_t head_flit,
  output logic           head_last,
  output logic           head_valid,
  input  logic           pop
);

  localparam int DEPTH = `NOC_BUFFER_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  noc_pkg::flit_t   mem_flit [DEPTH];
  logic             mem_last [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Circular increment, works for any depth
  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Full and empty from the fill count
  assign push_ready = (count != CNT_W'(DEPTH));
  assign head_valid = (count != '0);
  assign do_push    = push_valid && push_ready;
  assign do_pop     = pop && head_valid;

  // Head entry straight from storage
  assign head_flit = mem_flit[rd_ptr];
  assign head_last = mem_last[rd_ptr];

  // Flit storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_flit[wr_ptr] <= push_flit;
      mem_last[wr_ptr] <= push_last;
    end
  end

  // Pointers and fill count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop) rd_ptr <= next_ptr(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/noc_route_ctrl.sv
/*
 * Route and arbitration control for one router.
 * Each input routes its head flit X first, then Y, and holds that route
 * for the rest of the packet. Each output picks one requester round robin,
 * locks to it until the last flit has gone, and pops the granted input.
 */

`timescale 1ns/100ps
`default_nettype none

`include "noc_config.svh"

module noc_route_ctrl #(
  parameter int X_POS = 0,
  parameter int Y_POS = 0
) (
  input  logic               clk,
  input  logic               rst_n,
  input  noc_pkg::flit_t     head_flit [`NOC_PORTS],
  input  noc_pkg::port_vec_t head_last,
  input  noc_pkg::port_vec_t head_valid,
  input  noc_pkg::port_vec_t out_ready,
  output noc_pkg::dir_e      grant_sel [`NOC_PORTS],
  output noc_pkg::port_vec_t grant_valid,
  output noc_pkg::port_vec_t pop
);

  localparam int NP = `NOC_PORTS;

  // Per input
  noc_pkg::port_vec_t   in_packet;
  noc_pkg::dir_e        route_q   [NP];
  noc_pkg::dir_e        route_now [NP];
  // Per output, req[o][i] means input i wants output o
  noc_pkg::port_vec_t   req       [NP];
  noc_pkg::port_state_e state_q   [NP];
  noc_pkg::dir_e        sel_q     [NP];
  noc_pkg::dir_e        rr_q      [NP];
  noc_pkg::dir_e        arb_sel   [NP];
  noc_pkg::port_vec_t   arb_found;
  noc_pkg::port_vec_t   xfer;

  // Dimension order route from the destination field
  function automatic noc_pkg::dir_e xy_route(noc_pkg::flit_t flit);
    noc_pkg::node_id_t dest;
    int                dx;
    int                dy;
    dest = flit[`NOC_FLIT_WIDTH-1 -: `NOC_DEST_WIDTH];
    dx   = int'(dest) % `NOC_X;
    dy   = int'(dest) / `NOC_X;
    if (dx > X_POS) return noc_pkg::DIR_EAST;
    if (dx < X_POS) return noc_pkg::DIR_WEST;
    // Column reached, north is y + 1
    if (dy > Y_POS) return noc_pkg::DIR_NORTH;
    if (dy < Y_POS) return noc_pkg::DIR_SOUTH;
    return noc_pkg::DIR_LOCAL;
  endfunction

  // Port index plus offset, modulo the port count
  function automatic noc_pkg::dir_e wrap_idx(noc_pkg::dir_e base, int offset);
    int sum;
    sum = int'(base) + offset;
    if (sum >= NP) sum = sum - NP;
    return noc_pkg::dir_e'(sum);
  endfunction

  //////////////////////////////////////////////////
  // Routes and requests

  always_comb begin
    for (int o = 0; o < NP; o++) req[o] = '0;
    for (int i = 0; i < NP; i++) begin
      // Body flits follow the route the head took
      route_now[i] = in_packet[i] ? route_q[i] : xy_route(head_flit[i]);
      if (head_valid[i]) req[route_now[i]][i] = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Round robin pick and grant

  always_comb begin
    for (int o = 0; o < NP; o++) begin
      arb_found[o] = 1'b0;
      arb_sel[o]   = rr_q[o];
      // First requester at or after the pointer
      for (int k = 0; k < NP; k++) begin
        if (!arb_found[o] && req[o][wrap_idx(rr_q[o], k)]) begin
          arb_found[o] = 1'b1;
          arb_sel[o]   = wrap_idx(rr_q[o], k);
        end
      end
    end
  end

  always_comb begin
    pop = '0;
    for (int o = 0; o < NP; o++) begin
      if (state_q[o] == noc_pkg::PORT_BUSY) begin
        // Locked, the owner may have gaps between flits
        grant_sel[o]   = sel_q[o];
        grant_valid[o] = head_valid[sel_q[o]];
      end else begin
        grant_sel[o]   = arb_sel[o];
        grant_valid[o] = arb_found[o];
      end
      xfer[o] = grant_valid[o] && out_ready[o];
      if (xfer[o]) pop[grant_sel[o]] = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Output locks and input packet tracking

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_packet <= '0;
      for (int p = 0; p < NP; p++) begin
        route_q[p] <= noc_pkg::DIR_LOCAL;
        state_q[p] <= noc_pkg::PORT_IDLE;
        sel_q[p]   <= noc_pkg::DIR_LOCAL;
        rr_q[p]    <= noc_pkg::DIR_LOCAL;
      end
    end else begin
      for (int o = 0; o < NP; o++) begin
        if (state_q[o] == noc_pkg::PORT_IDLE && arb_found[o]) begin
          sel_q[o] <= arb_sel[o];
          rr_q[o]  <= wrap_idx(arb_sel[o], 1);
          // Single flit packet that goes out at once leaves it idle
          if (!(xfer[o] && head_last[arb_sel[o]])) state_q[o] <= noc_pkg::PORT_BUSY;
        end else if (state_q[o] == noc_pkg::PORT_BUSY && xfer[o] && head_last[sel_q[o]]) begin
          state_q[o] <= noc_pkg::PORT_IDLE;
        end
      end
      for (int i = 0; i < NP; i++) begin
        if (pop[i]) begin
          in_packet[i] <= !head_last[i];
          route_q[i]   <= route_now[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/noc_crossbar.sv
/*
 * Five by five flit crossbar.
 * Each output shows the flit and last bit of the input that the
 * controller granted to it. Outputs without a grant show zero.
 */

`timescale 1ns/100ps
`default_nettype none

`include "noc_config.svh"

module noc_crossbar (
  input  noc_pkg::flit_t     head_flit [`NOC_PORTS],
  input  noc_pkg::port_vec_t head_last,
  input  noc_pkg::dir_e      grant_sel [`NOC_PORTS],
  input  noc_pkg::port_vec_t grant_valid,
  output noc_pkg::flit_t     out_flit  [`NOC_PORTS],
  output noc_pkg::port_vec_t out_last,
  output noc_pkg::port_vec_t out_valid
);

  // One multiplexer per output
  always_comb begin
    for (int o = 0; o < `NOC_PORTS; o++) begin
      if (grant_valid[o]) begin
        out_flit[o] = head_flit[grant_sel[o]];
        out_last[o] = head_last[grant_sel[o]];
      end else begin
        // Quiet bus when nothing is granted
        out_flit[o] = '0;
        out_last[o] = 1'b0;
      end
    end
  end

  // A grant always has a flit behind it
  assign out_valid = grant_valid;

endmodule

`default_nettype wire

//--- logic/noc_router.sv
/*
 * Five port wormhole router for one mesh node.
 * Input buffers feed the route controller and the crossbar. Every per-port
 * array is indexed by noc_pkg::dir_e, local port at index 0.
 */

`timescale 1ns/100ps
`default_nettype none

`include "noc_config.svh"

module noc_router #(
  parameter int X_POS = 0,
  parameter int Y_POS = 0
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  noc_pkg::flit_t          in_flit [`NOC_PORTS],
  input  noc_pkg::port_vec_t      in_last,
  input  noc_pkg::port_vec_t      in_valid,
  output wire noc_pkg::port_vec_t in_ready,
  output noc_pkg::flit_t          out_flit [`NOC_PORTS],
  output noc_pkg::port_vec_t      out_last,
  output noc_pkg::port_vec_t      out_valid,
  input  noc_pkg::port_vec_t      out_ready
);

  // Buffer heads
  wire noc_pkg::flit_t     head_flit [`NOC_PORTS];
  wire noc_pkg::port_vec_t head_last;
  wire noc_pkg::port_vec_t head_valid;
  // Controller outputs
  noc_pkg::dir_e           grant_sel [`NOC_PORTS];
  noc_pkg::port_vec_t      grant_valid;
  noc_pkg::port_vec_t      pop;

  // One buffer per input direction
  for (genvar p = 0; p < `NOC_PORTS; p++) begin : g_in
    localparam noc_pkg::dir_e DIR = noc_pkg::dir_e'(p);

    noc_input_fifo u_fifo (
      .clk        (clk),
      .rst_n      (rst_n),
      .push_valid (in_valid[DIR]),
      .push_flit  (in_flit[DIR]),
      .push_last  (in_last[DIR]),
      .push_ready (in_ready[DIR]),
      .head_flit  (head_flit[DIR]),
      .head_last  (head_last[DIR]),
      .head_valid (head_valid[DIR]),
      .pop        (pop[DIR])
    );
  end

  noc_route_ctrl #(
    .X_POS (X_POS),
    .Y_POS (Y_POS)
  ) u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .head_flit   (head_flit),
    .head_last   (head_last),
    .head_valid  (head_valid),
    .out_ready   (out_ready),
    .grant_sel   (grant_sel),
    .grant_valid (grant_valid),
    .pop         (pop)
  );

  noc_crossbar u_xbar (
    .head_flit   (head_flit),
    .head_last   (head_last),
    .grant_sel   (grant_sel),
    .grant_valid (grant_valid),
    .out_flit    (out_flit),
    .out_last    (out_last),
    .out_valid   (out_valid)
  );

endmodule

`default_nettype wire

//--- logic/noc_mesh.sv
/*
 * Top of the 2D mesh network on chip.
 * One router per node, node number x + y * NOC_X. Each node exposes its
 * local port as a flit link in and a flit link out. East and north links
 * join neighbours, links off the mesh edge are tied off.
 */

`timescale 1ns/100ps
`default_nettype none

`include "noc_config.svh"

module noc_mesh (
  input  logic           clk,
  input  logic           rst_n,
  input  noc_pkg::flit_t in_flit   [`NOC_NODES],
  input  logic           in_last   [`NOC_NODES],
  input  logic           in_valid  [`NOC_NODES],
  output logic           in_ready  [`NOC_NODES],
  output noc_pkg::flit_t out_flit  [`NOC_NODES],
  output logic           out_last  [`NOC_NODES],
  output logic           out_valid [`NOC_NODES],
  input  logic           out_ready [`NOC_NODES]
);

  //////////////////////////////////////////////////
  // Router side wiring, [node][direction]

  wire noc_pkg::flit_t     node_in_flit   [`NOC_NODES][`NOC_PORTS];
  wire noc_pkg::port_vec_t node_in_last   [`NOC_NODES];
  wire noc_pkg::port_vec_t node_in_valid  [`NOC_NODES];
  wire noc_pkg::port_vec_t node_in_ready  [`NOC_NODES];
  wire noc_pkg::flit_t     node_out_flit  [`NOC_NODES][`NOC_PORTS];
  wire noc_pkg::port_vec_t node_out_last  [`NOC_NODES];
  wire noc_pkg::port_vec_t node_out_valid [`NOC_NODES];
  wire noc_pkg::port_vec_t node_out_ready [`NOC_NODES];

  for (genvar y = 0; y < `NOC_Y; y++) begin : g_y
    for (genvar x = 0; x < `NOC_X; x++) begin : g_x
      localparam int N = x + y * `NOC_X;

      noc_router #(
        .X_POS (x),
        .Y_POS (y)
      ) u_router (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_flit   (node_in_flit[N]),
        .in_last   (node_in_last[N]),
        .in_valid  (node_in_valid[N]),
        .in_ready  (node_in_ready[N]),
        .out_flit  (node_out_flit[N]),
        .out_last  (node_out_last[N]),
        .out_valid (node_out_valid[N]),
        .out_ready (node_out_ready[N])
      );

      // Local port to the node's own links
      assign node_in_flit[N][noc_pkg::DIR_LOCAL]   = in_flit[N];
      assign node_in_last[N][noc_pkg::DIR_LOCAL]   = in_last[N];
      assign node_in_valid[N][noc_pkg::DIR_LOCAL]  = in_valid[N];
      assign in_ready[N]                           = node_in_ready[N][noc_pkg::DIR_LOCAL];
      assign out_flit[N]                           = node_out_flit[N][noc_pkg::DIR_LOCAL];
      assign out_last[N]                           = node_out_last[N][noc_pkg::DIR_LOCAL];
      assign out_valid[N]                          = node_out_valid[N][noc_pkg::DIR_LOCAL];
      assign node_out_ready[N][noc_pkg::DIR_LOCAL] = out_ready[N];

      // East neighbour is N + 1
      if (x < `NOC_X - 1) begin : g_east
        assign node_in_flit[N][noc_pkg::DIR_EAST]   = node_out_flit[N+1][noc_pkg::DIR_WEST];
        assign node_in_last[N][noc_pkg::DIR_EAST]   = node_out_last[N+1][noc_pkg::DIR_WEST];
        assign node_in_valid[N][noc_pkg::DIR_EAST]  = node_out_valid[N+1][noc_pkg::DIR_WEST];
        assign node_out_ready[N][noc_pkg::DIR_EAST] = node_in_ready[N+1][noc_pkg::DIR_WEST];
      end else begin : g_east_edge
        assign node_in_flit[N][noc_pkg::DIR_EAST]   = '0;
        assign node_in_last[N][noc_pkg::DIR_EAST]   = 1'b0;
        assign node_in_valid[N][noc_pkg::DIR_EAST]  = 1'b0;
        assign node_out_ready[N][noc_pkg::DIR_EAST] = 1'b0;
      end

      // West neighbour is N - 1
      if (x > 0) begin : g_west
        assign node_in_flit[N][noc_pkg::DIR_WEST]   = node_out_flit[N-1][noc_pkg::DIR_EAST];
        assign node_in_last[N][noc_pkg::DIR_WEST]   = node_out_last[N-1][noc_pkg::DIR_EAST];
        assign node_in_valid[N][noc_pkg::DIR_WEST]  = node_out_valid[N-1][noc_pkg::DIR_EAST];
        assign node_out_ready[N][noc_pkg::DIR_WEST] = node_in_ready[N-1][noc_pkg::DIR_EAST];
      end else begin : g_west_edge
        assign node_in_flit[N][noc_pkg::DIR_WEST]   = '0;
        assign node_in_last[N][noc_pkg::DIR_WEST]   = 1'b0;
        assign node_in_valid[N][noc_pkg::DIR_WEST]  = 1'b0;
        assign node_out_ready[N][noc_pkg::DIR_WEST] = 1'b0;
      end

      // North is the next row up, y + 1
      if (y < `NOC_Y - 1) begin : g_north
        localparam int NN = N + `NOC_X;
        assign node_in_flit[N][noc_pkg::DIR_NORTH]   = node_out_flit[NN][noc_pkg::DIR_SOUTH];
        assign node_in_last[N][noc_pkg::DIR_NORTH]   = node_out_last[NN][noc_pkg::DIR_SOUTH];
        assign node_in_valid[N][noc_pkg::DIR_NORTH]  = node_out_valid[NN][noc_pkg::DIR_SOUTH];
        assign node_out_ready[N][noc_pkg::DIR_NORTH] = node_in_ready[NN][noc_pkg::DIR_SOUTH];
      end else begin : g_north_edge
        assign node_in_flit[N][noc_pkg::DIR_NORTH]   = '0;
        assign node_in_last[N][noc_pkg::DIR_NORTH]   = 1'b0;
        assign node_in_valid[N][noc_pkg::DIR_NORTH]  = 1'b0;
        assign node_out_ready[N][noc_pkg::DIR_NORTH] = 1'b0;
      end

      // South is the row below, y - 1
      if (y > 0) begin : g_south
        localparam int NS = N - `NOC_X;
        assign node_in_flit[N][noc_pkg::DIR_SOUTH]   = node_out_flit[NS][noc_pkg::DIR_NORTH];
        assign node_in_last[N][noc_pkg::DIR_SOUTH]   = node_out_last[NS][noc_pkg::DIR_NORTH];
        assign node_in_valid[N][noc_pkg::DIR_SOUTH]  = node_out_valid[NS][noc_pkg::DIR_NORTH];
        assign node_out_ready[N][noc_pkg::DIR_SOUTH] = node_in_ready[NS][noc_pkg::DIR_NORTH];
      end else begin : g_south_edge
        assign node_in_flit[N][noc_pkg::DIR_SOUTH]   = '0;
        assign node_in_last[N][noc_pkg::DIR_SOUTH]   = 1'b0;
        assign node_in_valid[N][noc_pkg::DIR_SOUTH]  = 1'b0;
        assign node_out_ready[N][noc_pkg::DIR_SOUTH] = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/noc_mesh_checker.sv
/*
 * Handshake assertions for the local links at the edge of the mesh.
 * Bound to noc_mesh from the testbench. Each node gets its own set of
 * properties, and assert_fails sums the failures of all of them.
 */

`timescale 1ns/100ps
`default_nettype none

`include "noc_config.svh"

module noc_mesh_checker (
  input logic           clk,
  input logic           rst_n,
  input logic           in_ready  [`NOC_NODES],
  input noc_pkg::flit_t out_flit  [`NOC_NODES],
  input logic           out_last  [`NOC_NODES],
  input logic           out_valid [`NOC_NODES],
  input logic           out_ready [`NOC_NODES]
);

  int unsigned node_fails [`NOC_NODES];
  int unsigned assert_fails;

  for (genvar n = 0; n < `NOC_NODES; n++) begin : g_node
    // Failure counts, one per property
    int unsigned hold_fails  = 0;
    int unsigned reset_fails = 0;
    int unsigned ready_fails = 0;

    // A stalled output keeps valid, flit and last until it is taken
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid[n] && !out_ready[n] |=>
        out_valid[n] && $stable(out_flit[n]) && $stable(out_last[n]))
    else begin
      hold_fails = hold_fails + 1;
      $error("node %0d dropped or changed a stalled output flit", n);
    end

    // Nothing leaves the mesh while reset is applied
    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid[n])
    else begin
      reset_fails = reset_fails + 1;
      $error("node %0d raised out_valid during reset", n);
    end

    // Local buffer empty and ready in the first cycle out of reset
    a_ready_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> in_ready[n])
    else begin
      ready_fails = ready_fails + 1;
      $error("node %0d in_ready low right after reset", n);
    end

    assign node_fails[n] = hold_fails + reset_fails + ready_fails;
  end

  // Total over all nodes, read by the testbench
  always_comb begin
    assert_fails = 0;
    for (int n = 0; n < `NOC_NODES; n++) begin
      assert_fails = assert_fails + node_fails[n];
    end
  end

endmodule

`default_nettype wire

//--- sim/noc_mesh_tb.sv
/*
 * Directed testbench for the 2D mesh network on chip.
 * Sending tasks drive the local links and queue the expected flits per
 * destination and source. A monitor takes every flit that leaves the mesh
 * and compares it with the queue. Run with noc_mesh_tb as top.
 */

`timescale 1ns/100ps
`default_nettype none

`include "noc_config.svh"

module noc_mesh_tb;

  localparam int NODES = `NOC_NODES;
  localparam int FW    = `NOC_FLIT_WIDTH;
  localparam int DW    = `NOC_DEST_WIDTH;
  // Flit fields below dest and src: packet seq 8, flit index 4, random rest
  localparam int RND_W = FW - 2 * DW - 12;
  // Roughly 700 cycles of tests at 8 ns, with wide margin
  localparam int WATCHDOG_NS = 20000;

  logic           clk;
  logic           rst_n;
  noc_pkg::flit_t in_flit   [NODES];
  logic           in_last   [NODES];
  logic           in_valid  [NODES];
  logic           in_ready  [NODES];
  noc_pkg::flit_t out_flit  [NODES];
  logic           out_last  [NODES];
  logic           out_valid [NODES];
  logic           out_ready [NODES];

  // Expected {last, flit}, indexed by dest * NODES + src
  logic [FW:0]    exp_q [NODES*NODES][$];
  bit             mid_pkt [NODES];
  int             cur_src [NODES];
  string          test_name;
  integer         seed;
  int             pkt_seq;
  int             mismatch_count;
  int             other_count;
  bit             stream_done;

  noc_mesh DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_flit   (in_flit),
    .in_last   (in_last),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_flit  (out_flit),
    .out_last  (out_last),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  bind noc_mesh noc_mesh_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_ready  (in_ready),
    .out_flit  (out_flit),
    .out_last  (out_last),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers

  task automatic check_value(input string name, input logic [FW:0] expected,
                             input logic [FW:0] actual);
    if (expected !== actual) begin
      mismatch_count++;
      $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // Dest and src in every flit, so body flits can be traced too
  function automatic noc_pkg::flit_t make_flit(int dst, int src, int seq, int idx, int rnd);
    noc_pkg::flit_t f;
    f = '0;
    f[FW-1 -: DW]       = dst[DW-1:0];
    f[FW-DW-1 -: DW]    = src[DW-1:0];
    f[FW-2*DW-1 -: 8]   = seq[7:0];
    f[FW-2*DW-9 -: 4]   = idx[3:0];
    f[RND_W-1:0]        = rnd[RND_W-1:0];
    return f;
  endfunction

  function automatic bit all_delivered();
    for (int q = 0; q < NODES * NODES; q++) begin
      if (exp_q[q].size() != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  // Entered right after a rising edge, returns after the last transfer
  task automatic send_packet(input int src, input int dst, input int len);
    noc_pkg::flit_t flit;
    logic           last;
    int             seq;
    seq = pkt_seq;
    pkt_seq++;
    for (int k = 0; k < len; k++) begin
      flit = make_flit(dst, src, seq, k, $random(seed));
      last = (k == len - 1);
      exp_q[dst * NODES + src].push_back({last, flit});
      in_flit[src]  <= flit;
      in_last[src]  <= last;
      in_valid[src] <= 1'b1;
      do @(posedge clk); while (!in_ready[src]);
    end
    in_valid[src] <= 1'b0;
  endtask

  task automatic wait_drained(input int max_cycles);
    int cycles;
    cycles = 0;
    while (!all_delivered() && cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    if (!all_delivered()) begin
      other_count++;
      $display("ERROR %s: flits still missing after %0d cycles", test_name, max_cycles);
    end
  endtask

  //////////////////////////////////////////////////
  // Output monitor

  always @(posedge clk) begin
    int          s;
    logic [FW:0] got;
    logic [FW:0] exp;
    if (rst_n) begin
      for (int d = 0; d < NODES; d++) begin
        if (out_valid[d] && out_ready[d]) begin
          got = {out_last[d], out_flit[d]};
          s   = int'(out_flit[d][FW-DW-1 -: DW]);
          // Wormhole keeps a packet contiguous at each output
          if (mid_pkt[d] && s != cur_src[d]) begin
            other_count++;
            $display("ERROR %s: node %0d got a flit from %0d inside a packet from %0d",
                     test_name, d, s, cur_src[d]);
          end
          if (exp_q[d * NODES + s].size() == 0) begin
            other_count++;
            $display("ERROR %s: node %0d got an unexpected flit %h", test_name, d, got);
          end else begin
            exp = exp_q[d * NODES + s].pop_front();
            check_value($sformatf("%s node %0d from %0d", test_name, d, s), exp, got);
          end
          mid_pkt[d] <= !out_last[d];
          cur_src[d] <= s;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Tests

  task automatic test_reset_state();
    test_name = "reset_state";
    for (int n = 0; n < NODES; n++) begin
      check_value($sformatf("%s node %0d out_valid", test_name, n),
                  (FW+1)'(0), (FW+1)'(out_valid[n]));
      check_value($sformatf("%s node %0d in_ready", test_name, n),
                  (FW+1)'(1), (FW+1)'(in_ready[n]));
    end
  endtask

  task automatic test_all_pairs();
    test_name = "all_pairs";
    for (int s = 0; s < NODES; s++) begin
      for (int d = 0; d < NODES; d++) begin
        send_packet(s, d, 1);
        wait_drained(100);
      end
    end
  endtask

  task automatic test_multi_flit();
    test_name = "multi_flit";
    for (int s = 0; s < NODES; s++) begin
      send_packet(s, NODES - 1 - s, 2 + s % 3);
      send_packet(s, (s + 1) % NODES, 4 - s % 3);
    end
    wait_drained(200);
  endtask

  task automatic test_contention();
    test_name = "contention";
    // Three sources into node 0
    fork
      begin
        send_packet(NODES - 1, 0, 3);
        send_packet(NODES - 1, 0, 2);
      end
      begin
        send_packet(NODES - 2, 0, 4);
        send_packet(NODES - 2, 0, 3);
      end
      begin
        send_packet(NODES - 3, 0, 2);
        send_packet(NODES - 3, 0, 4);
      end
    join
    wait_drained(200);
    // Two sources into the far corner
    fork
      send_packet(0, NODES - 1, 4);
      send_packet(1, NODES - 1, 4);
    join
    wait_drained(200);
  endtask

  task automatic test_back_pressure();
    integer rnd;
    test_name   = "back_pressure";
    stream_done = 1'b0;
    fork
      begin
        for (int p = 0; p < 6; p++) send_packet(0, NODES - 1, 4);
        stream_done = 1'b1;
      end
      begin
        while (!stream_done) begin
          @(posedge clk);
          rnd = $random(seed);
          out_ready[NODES - 1] <= rnd[0];
        end
      end
    join
    out_ready[NODES - 1] <= 1'b1;
    wait_drained(300);
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog

  initial begin
    seed           = 32'h0e3effe2;
    pkt_seq        = 0;
    mismatch_count = 0;
    other_count    = 0;
    stream_done    = 1'b0;
    rst_n          = 1'b0;
    for (int n = 0; n < NODES; n++) begin
      in_flit[n]   = '0;
      in_last[n]   = 1'b0;
      in_valid[n]  = 1'b0;
      out_ready[n] = 1'b1;
      mid_pkt[n]   = 1'b0;
      cur_src[n]   = 0;
    end
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    test_reset_state();
    test_all_pairs();
    test_multi_flit();
    test_contention();
    test_back_pressure();
    repeat (2) @(posedge clk);
    $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatch_count, other_count, DUT.u_checker.assert_fails);
    if (mismatch_count + other_count + DUT.u_checker.assert_fails == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: watchdog timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+logic
logic/noc_pkg.sv
logic/noc_input_fifo.sv
logic/noc_route_ctrl.sv
logic/noc_crossbar.sv
logic/noc_router.sv
logic/noc_mesh.sv
sim/noc_mesh_checker.sv
sim/noc_mesh_tb.sv
